/* Makefile */
SRCS := $(wildcard *.sv)

.PHONY: all run clean

all: run

obj_dir/VtbTop: $(SRCS) verilog.f
	verilator --binary --timing --top-module tbTop -f verilog.f

run: obj_dir/VtbTop
	@out="$$(./obj_dir/VtbTop)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF '*** TEST PASSED ***'

clean:
	rm -rf obj_dir

/* mipsAlu.sv */
`timescale 1ns/1ps

module mipsAlu (
    input  mipsPkg::word_t  a,
    input  mipsPkg::word_t  b,
    input  mipsPkg::aluOp_t op,
    output mipsPkg::word_t  y,
    output logic            zero
);

    logic lessThan;

    // Signed compare for slt
    assign lessThan = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            mipsPkg::ALU_SUB: y = a - b;
            mipsPkg::ALU_AND: y = a & b;
            mipsPkg::ALU_OR:  y = a | b;
            mipsPkg::ALU_SLT: y = {31'b0, lessThan};
            default:          y = a + b;
        endcase
    end

    assign zero = (y == '0);

endmodule

/* mipsController.sv */
`timescale 1ns/1ps

module mipsController (
    input  logic   clk,
    input  logic   rst,
    mipsCtrlIf.ctrl ctl
);

    mipsPkg::ctrlState_t state;
    mipsPkg::ctrlState_t stateNext;
    mipsPkg::aluOp_t     rtypeOp;

    // ==============================
    // State register
    // ==============================
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= mipsPkg::FETCH;
        end else begin
            state <= stateNext;
        end
    end

    always_comb begin
        stateNext = mipsPkg::FETCH;
        case (state)
            mipsPkg::FETCH:  stateNext = mipsPkg::DECODE;
            mipsPkg::DECODE: begin
                case (ctl.opcode)
                    mipsPkg::OP_RTYPE: stateNext = mipsPkg::RTEXEC;
                    mipsPkg::OP_LW:    stateNext = mipsPkg::MEMADR;
                    mipsPkg::OP_SW:    stateNext = mipsPkg::MEMADR;
                    mipsPkg::OP_ADDIU: stateNext = mipsPkg::ADDIEXEC;
                    mipsPkg::OP_BEQ:   stateNext = mipsPkg::BRANCH;
                    mipsPkg::OP_J:     stateNext = mipsPkg::JUMP;
                    // Unknown opcode is dropped
                    default:           stateNext = mipsPkg::FETCH;
                endcase
            end
            mipsPkg::MEMADR: begin
                if (ctl.opcode == mipsPkg::OP_LW) begin
                    stateNext = mipsPkg::MEMRD;
                end else begin
                    stateNext = mipsPkg::MEMWR;
                end
            end
            mipsPkg::MEMRD:    stateNext = mipsPkg::MEMWB;
            mipsPkg::RTEXEC:   stateNext = mipsPkg::ALUWB;
            mipsPkg::ADDIEXEC: stateNext = mipsPkg::ALUWB;
            default:           stateNext = mipsPkg::FETCH;
        endcase
    end

    // R-type funct decode, add when unknown
    always_comb begin
        case (ctl.funct)
            mipsPkg::FN_SUBU: rtypeOp = mipsPkg::ALU_SUB;
            mipsPkg::FN_AND:  rtypeOp = mipsPkg::ALU_AND;
            mipsPkg::FN_OR:   rtypeOp = mipsPkg::ALU_OR;
            mipsPkg::FN_SLT:  rtypeOp = mipsPkg::ALU_SLT;
            default:          rtypeOp = mipsPkg::ALU_ADD;
        endcase
    end

    // ==============================
    // Control outputs per state
    // ==============================
    always_comb begin
        ctl.pcEn     = 1'b0;
        ctl.branch   = 1'b0;
        ctl.iorD     = 1'b0;
        ctl.irWrite  = 1'b0;
        ctl.regDst   = 1'b0;
        ctl.memToReg = 1'b0;
        ctl.regWrite = 1'b0;
        ctl.aluSrcA  = 1'b0;
        ctl.aluSrcB  = 2'b00;
        ctl.aluOp    = mipsPkg::ALU_ADD;
        ctl.pcSrc    = 2'b00;
        ctl.memWrite = 1'b0;
        case (state)
            mipsPkg::FETCH: begin
                // PC + 4 written back while the instruction is latched
                ctl.irWrite = 1'b1;
                ctl.pcEn    = 1'b1;
                ctl.aluSrcB = 2'b01;
            end
            // Branch target precomputed into the ALU register
            mipsPkg::DECODE: ctl.aluSrcB = 2'b11;
            mipsPkg::MEMADR: begin
                ctl.aluSrcA = 1'b1;
                ctl.aluSrcB = 2'b10;
            end
            mipsPkg::MEMRD: ctl.iorD = 1'b1;
            mipsPkg::MEMWB: begin
                ctl.memToReg = 1'b1;
                ctl.regWrite = 1'b1;
            end
            mipsPkg::MEMWR: begin
                ctl.iorD     = 1'b1;
                ctl.memWrite = 1'b1;
            end
            mipsPkg::RTEXEC: begin
                ctl.aluSrcA = 1'b1;
                ctl.aluOp   = rtypeOp;
            end
            mipsPkg::ALUWB: begin
                // Shared by R-type and addiu
                ctl.regDst   = (ctl.opcode == mipsPkg::OP_RTYPE);
                ctl.regWrite = 1'b1;
            end
            mipsPkg::ADDIEXEC: begin
                ctl.aluSrcA = 1'b1;
                ctl.aluSrcB = 2'b10;
            end
            mipsPkg::BRANCH: begin
                ctl.aluSrcA = 1'b1;
                ctl.aluOp   = mipsPkg::ALU_SUB;
                ctl.branch  = 1'b1;
                ctl.pcSrc   = 2'b01;
            end
            mipsPkg::JUMP: begin
                ctl.pcEn  = 1'b1;
                ctl.pcSrc = 2'b10;
            end
            default: ;
        endcase
    end

endmodule

/* mipsCtrlIf.sv */
`timescale 1ns/1ps

interface mipsCtrlIf;

    // Controller to datapath
    logic            pcEn;
    logic            branch;
    logic            iorD;
    logic            irWrite;
    logic            regDst;
    logic            memToReg;
    logic            regWrite;
    logic            aluSrcA;
    logic [1:0]      aluSrcB;
    mipsPkg::aluOp_t aluOp;
    logic [1:0]      pcSrc;
    logic            memWrite;

    // Datapath back to controller
    logic [5:0]      opcode;
    logic [5:0]      funct;
    logic            zero;

    modport ctrl (
        output pcEn, branch, iorD, irWrite, regDst, memToReg, regWrite,
               aluSrcA, aluSrcB, aluOp, pcSrc, memWrite,
        input  opcode, funct
    );

    modport dp (
        input  pcEn, branch, iorD, irWrite, regDst, memToReg, regWrite,
               aluSrcA, aluSrcB, aluOp, pcSrc, memWrite,
        output opcode, funct, zero
    );

endinterface

/* mipsDatapath.sv */
`timescale 1ns/1ps

module mipsDatapath #(
    parameter mipsPkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst,
    mipsCtrlIf.dp          ctl,
    input  mipsPkg::word_t memReadData,
    output mipsPkg::word_t memAddr,
    output mipsPkg::word_t memWriteData,
    output logic           memWrite
);

    mipsPkg::word_t  pc;
    mipsPkg::word_t  pcNext;
    mipsPkg::word_t  ir;
    mipsPkg::word_t  mdr;
    mipsPkg::word_t  aReg;
    mipsPkg::word_t  bReg;
    mipsPkg::word_t  aluOut;
    mipsPkg::word_t  rd1;
    mipsPkg::word_t  rd2;
    mipsPkg::word_t  srcA;
    mipsPkg::word_t  srcB;
    mipsPkg::word_t  aluResult;
    mipsPkg::word_t  signImm;
    mipsPkg::word_t  signImmSh;
    mipsPkg::word_t  jumpTarget;
    mipsPkg::word_t  writeData;
    mipsPkg::regIdx_t writeReg;
    logic            aluZero;
    logic            pcWrite;

    // ==============================
    // Program counter
    // ==============================
    assign pcWrite = ctl.pcEn | (ctl.branch & ctl.zero);

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (pcWrite) begin
            pc <= pcNext;
        end
    end

    // Upper PC bits come from the already incremented PC
    assign jumpTarget = {pc[31:28], ir[25:0], 2'b00};

    always_comb begin
        case (ctl.pcSrc)
            2'b01:   pcNext = aluOut;
            2'b10:   pcNext = jumpTarget;
            default: pcNext = aluResult;
        endcase
    end

    // ==============================
    // Non-architectural registers
    // ==============================
    always_ff @(posedge clk) begin
        if (ctl.irWrite) begin
            ir <= memReadData;
        end
        mdr    <= memReadData;
        aReg   <= rd1;
        bReg   <= rd2;
        aluOut <= aluResult;
    end

    assign ctl.opcode = ir[31:26];
    assign ctl.funct  = ir[5:0];

    // Memory port
    assign memAddr      = ctl.iorD ? aluOut : pc;
    assign memWriteData = bReg;
    assign memWrite     = ctl.memWrite;

    // Register file write side
    assign writeReg  = ctl.regDst ? ir[15:11] : ir[20:16];
    assign writeData = ctl.memToReg ? mdr : aluOut;

    mipsRegFile u_regFile (
        .clk (clk),
        .rst (rst),
        .ra1 (ir[25:21]),
        .ra2 (ir[20:16]),
        .wa  (writeReg),
        .we  (ctl.regWrite),
        .wd  (writeData),
        .rd1 (rd1),
        .rd2 (rd2)
    );

    // Immediate and operand selection
    assign signImm   = {{16{ir[15]}}, ir[15:0]};
    assign signImmSh = {signImm[29:0], 2'b00};
    assign srcA      = ctl.aluSrcA ? aReg : pc;

    always_comb begin
        case (ctl.aluSrcB)
            2'b00:   srcB = bReg;
            2'b01:   srcB = 32'd4;
            2'b10:   srcB = signImm;
            default: srcB = signImmSh;
        endcase
    end

    mipsAlu u_alu (
        .a    (srcA),
        .b    (srcB),
        .op   (ctl.aluOp),
        .y    (aluResult),
        .zero (aluZero)
    );

    assign ctl.zero = aluZero;

endmodule

/* mipsPkg.sv */
package mipsPkg;

    // ==============================
    // Basic widths
    // ==============================
    typedef logic [31:0] word_t;
    typedef logic [4:0]  regIdx_t;

    // ==============================
    // Instruction encodings
    // ==============================
    localparam logic [5:0] OP_RTYPE = 6'h00;
    localparam logic [5:0] OP_J     = 6'h02;
    localparam logic [5:0] OP_BEQ   = 6'h04;
    localparam logic [5:0] OP_ADDIU = 6'h09;
    localparam logic [5:0] OP_LW    = 6'h23;
    localparam logic [5:0] OP_SW    = 6'h2b;

    // R-type funct field
    localparam logic [5:0] FN_ADDU = 6'h21;
    localparam logic [5:0] FN_SUBU = 6'h23;
    localparam logic [5:0] FN_AND  = 6'h24;
    localparam logic [5:0] FN_OR   = 6'h25;
    localparam logic [5:0] FN_SLT  = 6'h2a;

    // ==============================
    // Control types
    // ==============================
    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLT
    } aluOp_t;

    typedef enum logic [3:0] {
        FETCH, DECODE, MEMADR, MEMRD, MEMWB, MEMWR,
        RTEXEC, ALUWB, ADDIEXEC, BRANCH, JUMP
    } ctrlState_t;

endpackage

/* mipsRegFile.sv */
`timescale 1ns/1ps

module mipsRegFile (
    input  logic             clk,
    input  logic             rst,
    input  mipsPkg::regIdx_t ra1,
    input  mipsPkg::regIdx_t ra2,
    input  mipsPkg::regIdx_t wa,
    input  logic             we,
    input  mipsPkg::word_t   wd,
    output mipsPkg::word_t   rd1,
    output mipsPkg::word_t   rd2
);

    mipsPkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (wa != '0)) begin
            regs[wa] <= wd;
        end
    end

    // Register zero is hardwired
    assign rd1 = (ra1 == '0) ? '0 : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : regs[ra2];

endmodule

/* mipsTop.sv */
`timescale 1ns/1ps

module mipsTop #(
    parameter mipsPkg::word_t RESET_PC = 32'h0000_0000
) (
    input  logic           clk,
    input  logic           rst,
    input  mipsPkg::word_t memReadData,
    output mipsPkg::word_t memAddr,
    output mipsPkg::word_t memWriteData,
    output logic           memWrite
);

    // Control bundle between FSM and datapath
    mipsCtrlIf ctlBus ();

    mipsController u_controller (
        .clk (clk),
        .rst (rst),
        .ctl (ctlBus.ctrl)
    );

    mipsDatapath #(
        .RESET_PC (RESET_PC)
    ) u_datapath (
        .clk          (clk),
        .rst          (rst),
        .ctl          (ctlBus.dp),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite)
    );

endmodule

/* tbChecker.sv */
`timescale 1ns/1ps

module tbChecker #(
    parameter mipsPkg::word_t RESET_PC  = 32'h0000_0000,
    parameter int             MAX_INSTR = 100
) (
    input  logic           clk,
    input  logic           rst,
    input  mipsPkg::word_t image [64],
    input  mipsPkg::word_t memAddr,
    input  mipsPkg::word_t memWriteData,
    input  logic           memWrite,
    input  logic           testEnd,
    input  int             testNum,
    output int             passCount,
    output int             failCount
);

    // Expected stores in program order
    mipsPkg::word_t expAddr [$];
    mipsPkg::word_t expData [$];
    int             expIdx;
    int             testErrors;
    bit             rstPrev;

    // ==============================
    // ISA reference model
    // ==============================
    function automatic void buildExpected();
        mipsPkg::word_t m [64];
        mipsPkg::word_t r [32];
        mipsPkg::word_t pc;
        mipsPkg::word_t nextPc;
        mipsPkg::word_t ins;
        mipsPkg::word_t imm;
        mipsPkg::word_t addr;
        logic [4:0]     rs;
        logic [4:0]     rt;
        logic [4:0]     rd;
        bit             halted;
        for (int i = 0; i < 64; i++) begin
            m[i] = image[i];
        end
        for (int i = 0; i < 32; i++) begin
            r[i] = '0;
        end
        expAddr.delete();
        expData.delete();
        pc = RESET_PC;
        halted = 1'b0;
        for (int n = 0; n < MAX_INSTR && !halted; n++) begin
            ins = m[pc[7:2]];
            rs = ins[25:21];
            rt = ins[20:16];
            rd = ins[15:11];
            imm = {{16{ins[15]}}, ins[15:0]};
            nextPc = pc + 32'd4;
            case (ins[31:26])
                mipsPkg::OP_RTYPE: begin
                    case (ins[5:0])
                        mipsPkg::FN_SUBU: r[rd] = r[rs] - r[rt];
                        mipsPkg::FN_AND:  r[rd] = r[rs] & r[rt];
                        mipsPkg::FN_OR:   r[rd] = r[rs] | r[rt];
                        mipsPkg::FN_SLT:
                            r[rd] = ($signed(r[rs]) < $signed(r[rt])) ? 32'd1 : 32'd0;
                        // Unknown funct behaves as add
                        default:          r[rd] = r[rs] + r[rt];
                    endcase
                end
                mipsPkg::OP_ADDIU: r[rt] = r[rs] + imm;
                mipsPkg::OP_LW: begin
                    addr = r[rs] + imm;
                    r[rt] = m[addr[7:2]];
                end
                mipsPkg::OP_SW: begin
                    addr = r[rs] + imm;
                    m[addr[7:2]] = r[rt];
                    expAddr.push_back(addr);
                    expData.push_back(r[rt]);
                end
                mipsPkg::OP_BEQ: begin
                    if (r[rs] == r[rt]) begin
                        nextPc = nextPc + {imm[29:0], 2'b00};
                    end
                end
                mipsPkg::OP_J: begin
                    nextPc = {nextPc[31:28], ins[25:0], 2'b00};
                    // Jump to itself ends the program
                    halted = (nextPc == pc);
                end
                default: ;
            endcase
            r[0] = '0;
            pc = nextPc;
        end
    endfunction

    task automatic checkStore();
        if (expIdx >= expAddr.size()) begin
            $display("test %0d: extra store to address %h with data %h at %0t",
                     testNum, memAddr, memWriteData, $time);
            testErrors++;
        end else begin
            if (memAddr !== expAddr[expIdx]) begin
                $display("MISMATCH time=%0t signal=memAddr expected=%h actual=%h",
                         $time, expAddr[expIdx], memAddr);
                testErrors++;
            end
            if (memWriteData !== expData[expIdx]) begin
                $display("MISMATCH time=%0t signal=memWriteData expected=%h actual=%h",
                         $time, expData[expIdx], memWriteData);
                testErrors++;
            end
            expIdx++;
        end
    endtask

    task automatic finishTest();
        if (expIdx < expAddr.size()) begin
            $display("test %0d: only %0d of %0d expected stores happened",
                     testNum, expIdx, expAddr.size());
            testErrors++;
        end
        if (testErrors == 0) begin
            $display("test %0d: pass, %0d stores checked", testNum, expIdx);
            passCount++;
        end else begin
            $display("test %0d: fail, %0d errors", testNum, testErrors);
            failCount++;
        end
        testErrors = 0;
    endtask

    // ==============================
    // Compare process
    // ==============================
    always @(posedge clk) begin
        if (rst) begin
            // First reset edge may still carry a store from the old run
            if (rstPrev && memWrite) begin
                $display("test %0d: memWrite high during reset at %0t", testNum, $time);
                testErrors++;
            end
            buildExpected();
            expIdx = 0;
        end else if (memWrite) begin
            checkStore();
        end
        if (testEnd) begin
            finishTest();
        end
        rstPrev = rst;
    end

endmodule

/* tbClock.sv */
`timescale 1ns/1ps

module tbClock #(
    parameter int PERIOD_NS = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

/* tbTop.sv */
`timescale 1ns/1ps

module tbTop;

    localparam int NUM_TESTS  = 6;
    localparam int RST_CYCLES = 8;
    localparam int BUDGET     = 200;
    localparam int PERIOD_NS  = 8;

    logic           clk;
    logic           rst;
    logic           testEnd;
    int             testNum;
    int             passCount;
    int             failCount;
    integer         seed;
    int             pAt;
    mipsPkg::word_t memAddr;
    mipsPkg::word_t memWriteData;
    mipsPkg::word_t memReadData;
    logic           memWrite;

    // Program image and the live memory it is copied into
    mipsPkg::word_t image [64];
    mipsPkg::word_t mem [64];

    tbClock #(.PERIOD_NS(PERIOD_NS)) clockGen (.clk(clk));

    mipsTop #(
        .RESET_PC (32'h0000_0000)
    ) i_mipsTop (
        .clk          (clk),
        .rst          (rst),
        .memReadData  (memReadData),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite)
    );

    tbChecker #(
        .RESET_PC (32'h0000_0000)
    ) storeChecker (
        .clk          (clk),
        .rst          (rst),
        .image        (image),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memWrite     (memWrite),
        .testEnd      (testEnd),
        .testNum      (testNum),
        .passCount    (passCount),
        .failCount    (failCount)
    );

    // ==============================
    // Memory model
    // ==============================
    assign memReadData = mem[memAddr[7:2]];

    always @(posedge clk) begin
        // Reloaded from the image on every reset cycle
        if (rst) begin
            for (int i = 0; i < 64; i++) begin
                mem[i] <= image[i];
            end
        end else if (memWrite) begin
            mem[memAddr[7:2]] <= memWriteData;
        end
    end

    // ==============================
    // Program assembly
    // ==============================
    function automatic mipsPkg::word_t rFormat(input logic [5:0] funct,
                                               input int rd, input int rs, input int rt);
        return {mipsPkg::OP_RTYPE, rs[4:0], rt[4:0], rd[4:0], 5'd0, funct};
    endfunction

    function automatic mipsPkg::word_t iFormat(input logic [5:0] op,
                                               input int rt, input int rs, input int imm);
        return {op, rs[4:0], rt[4:0], imm[15:0]};
    endfunction

    // Target is a word index
    function automatic mipsPkg::word_t jFormat(input int target);
        return {mipsPkg::OP_J, target[25:0]};
    endfunction

    task automatic startProgram();
        for (int i = 0; i < 64; i++) begin
            image[i] = '0;
        end
        pAt = 0;
    endtask

    task automatic emit(input mipsPkg::word_t w);
        image[pAt] = w;
        pAt++;
    endtask

    task automatic emitSelfJump();
        emit(jFormat(pAt));
    endtask

    // Data lives at 0x80, results go to 0xC0
    task automatic buildRtype();
        startProgram();
        image[32] = 32'd100;
        image[33] = 32'hFFFF_FFF6;
        image[34] = 32'h0F0F_00FF;
        image[35] = 32'h00FF_0F0F;
        for (int i = 1; i < 5; i++) begin
            emit(iFormat(mipsPkg::OP_LW, i, 0, 'h7C + 4 * i));
        end
        emit(rFormat(mipsPkg::FN_ADDU, 5, 1, 2));
        emit(iFormat(mipsPkg::OP_SW, 5, 0, 'hC0));
        emit(rFormat(mipsPkg::FN_SUBU, 5, 1, 2));
        emit(iFormat(mipsPkg::OP_SW, 5, 0, 'hC4));
        emit(rFormat(mipsPkg::FN_AND, 5, 3, 4));
        emit(iFormat(mipsPkg::OP_SW, 5, 0, 'hC8));
        emit(rFormat(mipsPkg::FN_OR, 5, 3, 4));
        emit(iFormat(mipsPkg::OP_SW, 5, 0, 'hCC));
        // Negative against positive, both orders
        emit(rFormat(mipsPkg::FN_SLT, 5, 2, 1));
        emit(iFormat(mipsPkg::OP_SW, 5, 0, 'hD0));
        emit(rFormat(mipsPkg::FN_SLT, 5, 1, 2));
        emit(iFormat(mipsPkg::OP_SW, 5, 0, 'hD4));
        emitSelfJump();
    endtask

    task automatic buildAddiu();
        startProgram();
        emit(iFormat(mipsPkg::OP_ADDIU, 1, 0, 'h1234));
        emit(iFormat(mipsPkg::OP_SW, 1, 0, 'hC0));
        emit(iFormat(mipsPkg::OP_ADDIU, 2, 1, -1));
        emit(iFormat(mipsPkg::OP_SW, 2, 0, 'hC4));
        emit(iFormat(mipsPkg::OP_ADDIU, 3, 0, -32768));
        emit(iFormat(mipsPkg::OP_SW, 3, 0, 'hC8));
        emit(iFormat(mipsPkg::OP_ADDIU, 4, 3, 32767));
        emit(iFormat(mipsPkg::OP_SW, 4, 0, 'hCC));
        emitSelfJump();
    endtask

    task automatic buildRoundTrip();
        startProgram();
        for (int i = 32; i < 36; i++) begin
            image[i] = $random(seed);
        end
        emit(iFormat(mipsPkg::OP_LW, 1, 0, 'h80));
        emit(iFormat(mipsPkg::OP_LW, 2, 0, 'h84));
        // Base register with negative offsets
        emit(iFormat(mipsPkg::OP_ADDIU, 6, 0, 'h90));
        emit(iFormat(mipsPkg::OP_LW, 3, 6, -4));
        emit(iFormat(mipsPkg::OP_LW, 4, 6, -8));
        emit(rFormat(mipsPkg::FN_SUBU, 5, 1, 3));
        emit(iFormat(mipsPkg::OP_SW, 5, 0, 'hC0));
        emit(iFormat(mipsPkg::OP_SW, 2, 0, 'hC4));
        emit(iFormat(mipsPkg::OP_ADDIU, 7, 0, 'hD0));
        emit(iFormat(mipsPkg::OP_SW, 4, 7, 4));
        emit(iFormat(mipsPkg::OP_SW, 1, 7, -8));
        // Read back a stored word
        emit(iFormat(mipsPkg::OP_LW, 2, 0, 'hC0));
        emit(rFormat(mipsPkg::FN_OR, 5, 2, 4));
        emit(iFormat(mipsPkg::OP_SW, 5, 0, 'hCC));
        emitSelfJump();
    endtask

    task automatic buildBranches();
        startProgram();
        emit(iFormat(mipsPkg::OP_ADDIU, 1, 0, 5));
        emit(iFormat(mipsPkg::OP_ADDIU, 2, 0, 5));
        emit(iFormat(mipsPkg::OP_ADDIU, 3, 0, 7));
        emit(iFormat(mipsPkg::OP_BEQ, 2, 1, 1));
        emit(iFormat(mipsPkg::OP_SW, 1, 0, 'hC0));
        emit(iFormat(mipsPkg::OP_SW, 2, 0, 'hC4));
        emit(iFormat(mipsPkg::OP_BEQ, 3, 1, 1));
        emit(iFormat(mipsPkg::OP_SW, 3, 0, 'hC8));
        // Jump over two stores
        emit(jFormat(pAt + 3));
        emit(iFormat(mipsPkg::OP_SW, 1, 0, 'hCC));
        emit(iFormat(mipsPkg::OP_SW, 2, 0, 'hD0));
        emit(iFormat(mipsPkg::OP_SW, 3, 0, 'hD4));
        emitSelfJump();
    endtask

    task automatic buildRandom();
        int rnd;
        int rd;
        int rs;
        int rt;
        startProgram();
        for (int i = 1; i < 8; i++) begin
            image[31 + i] = $random(seed);
            emit(iFormat(mipsPkg::OP_LW, i, 0, 'h7C + 4 * i));
        end
        for (int n = 0; n < 12; n++) begin
            rnd = $random(seed);
            // Registers 1 to 7
            rd = 1 + ((rnd >> 4) & 7) % 7;
            rs = 1 + ((rnd >> 7) & 7) % 7;
            rt = 1 + ((rnd >> 10) & 7) % 7;
            case (rnd & 7)
                0: emit(rFormat(mipsPkg::FN_ADDU, rd, rs, rt));
                1: emit(rFormat(mipsPkg::FN_SUBU, rd, rs, rt));
                2: emit(rFormat(mipsPkg::FN_AND, rd, rs, rt));
                3: emit(rFormat(mipsPkg::FN_OR, rd, rs, rt));
                4: emit(rFormat(mipsPkg::FN_SLT, rd, rs, rt));
                default: emit(iFormat(mipsPkg::OP_ADDIU, rd, rs, rnd >> 16));
            endcase
        end
        // At least one write aimed at register zero
        emit(iFormat(mipsPkg::OP_ADDIU, 0, 7, 'h55));
        for (int i = 0; i < 8; i++) begin
            emit(iFormat(mipsPkg::OP_SW, i, 0, 'hC0 + 4 * i));
        end
        emitSelfJump();
    endtask

    // ==============================
    // Test sequencing
    // ==============================
    task automatic runTest(input int num, input int resetAfter);
        @(posedge clk);
        rst     <= 1'b1;
        testNum <= num;
        repeat (RST_CYCLES) @(posedge clk);
        rst <= 1'b0;
        if (resetAfter > 0) begin
            // Restart while the program is running
            repeat (resetAfter) @(posedge clk);
            rst <= 1'b1;
            repeat (RST_CYCLES) @(posedge clk);
            rst <= 1'b0;
        end
        repeat (BUDGET) @(posedge clk);
        testEnd <= 1'b1;
        @(posedge clk);
        testEnd <= 1'b0;
    endtask

    initial begin
        rst     = 1'b1;
        testEnd = 1'b0;
        testNum = 0;
        seed    = 37;
        buildRtype();
        runTest(1, 0);
        buildAddiu();
        runTest(2, 0);
        buildRoundTrip();
        runTest(3, 0);
        buildBranches();
        runTest(4, 0);
        buildRandom();
        runTest(5, 0);
        buildAddiu();
        runTest(6, 18);
        repeat (2) @(posedge clk);
        $display("tests run: %0d, passed: %0d, failed: %0d", NUM_TESTS, passCount, failCount);
        if (failCount == 0 && passCount == NUM_TESTS) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

    // Margin covers the mid-program reset and the per-test handoff cycles
    initial begin
        #((NUM_TESTS * (BUDGET + RST_CYCLES) + 400) * PERIOD_NS);
        $display("Timeout: the tests did not finish in the expected time");
        $display("*** TEST FAILED ***");
        $finish;
    end

endmodule

/* verilog.f */
mipsPkg.sv
mipsCtrlIf.sv
mipsAlu.sv
mipsRegFile.sv
mipsController.sv
mipsDatapath.sv
mipsTop.sv
tbClock.sv
tbChecker.sv
tbTop.sv
